/* hdl/stream_buffer_pkg.sv */
`default_nettype none

package stream_buffer_pkg;

	// bank geometry
	localparam int unsigned DATA_WIDTH = 16;
	localparam int unsigned ADDR_WIDTH = 6;
	localparam int unsigned DEPTH = 1 << ADDR_WIDTH;

	// walk dimensions, lane changes fastest
	localparam int unsigned LANES = 4;
	localparam int unsigned CHANNELS = 4;
	localparam int unsigned WINDOWS = 8;

	localparam int unsigned READ_LATENCY = 3; // raddr reg + array reg + output pipe
	localparam int unsigned SWEEP_READS = LANES * CHANNELS * WINDOWS;

	localparam int unsigned LANE_BITS = $clog2(LANES);
	localparam int unsigned CHAN_BITS = $clog2(CHANNELS);
	localparam int unsigned WIN_BITS = $clog2(WINDOWS);

	typedef logic [DATA_WIDTH-1:0] feature_t;
	typedef logic [ADDR_WIDTH-1:0] bank_addr_t;

	localparam bank_addr_t WINDOW_STRIDE = bank_addr_t'(4);

	// terminal counts of the walker counters
	localparam logic [LANE_BITS-1:0] LANE_LAST = LANE_BITS'(LANES - 1);
	localparam logic [CHAN_BITS-1:0] CHAN_LAST = CHAN_BITS'(CHANNELS - 1);
	localparam logic [WIN_BITS-1:0] WIN_LAST = WIN_BITS'(WINDOWS - 1);

	typedef struct packed {
		logic en;
		bank_addr_t addr;
		feature_t data;
	} bank_write_t;

	typedef struct packed {
		feature_t b0; // bank 0 word
		feature_t b1; // bank 1 word, same address
	} feature_pair_t;

endpackage

`default_nettype wire

/* hdl/feature_ram.sv */
`default_nettype none

module feature_ram (
	input wire clk,
	input wire i_we,
	input wire stream_buffer_pkg::bank_addr_t i_waddr,
	input wire stream_buffer_pkg::feature_t i_wdata,
	input wire stream_buffer_pkg::bank_addr_t i_raddr,
	output stream_buffer_pkg::feature_t o_rdata
);

	stream_buffer_pkg::feature_t mem [0:stream_buffer_pkg::DEPTH-1];

	stream_buffer_pkg::bank_addr_t raddr_q;
	stream_buffer_pkg::feature_t rdata_q;
	stream_buffer_pkg::feature_t rdata_pipe;

	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// same-address read during write sees the old word
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		rdata_q <= mem[raddr_q];
		rdata_pipe <= rdata_q; // extra stage for timing
	end

	assign o_rdata = rdata_pipe;

endmodule

`default_nettype wire

/* hdl/feature_walker.sv */
`default_nettype none

module feature_walker (
	input wire clk,
	input wire i_reset,
	input wire i_go,
	output stream_buffer_pkg::bank_addr_t o_addr,
	output logic o_valid,
	output logic o_last
);

	logic active;
	logic [stream_buffer_pkg::LANE_BITS-1:0] lane_cnt;
	logic [stream_buffer_pkg::CHAN_BITS-1:0] chan_cnt;
	logic [stream_buffer_pkg::WIN_BITS-1:0] win_cnt;
	stream_buffer_pkg::bank_addr_t win_base; // first address of current window
	stream_buffer_pkg::bank_addr_t base_addr; // window start + channel
	stream_buffer_pkg::bank_addr_t offset; // lane offset
	logic lane_wrap;
	logic chan_wrap;
	logic final_addr;

	assign lane_wrap = (lane_cnt == stream_buffer_pkg::LANE_LAST);
	assign chan_wrap = (chan_cnt == stream_buffer_pkg::CHAN_LAST);
	assign final_addr = active && lane_wrap && chan_wrap &&
		(win_cnt == stream_buffer_pkg::WIN_LAST);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			active <= 1'b0;
			lane_cnt <= '0;
			chan_cnt <= '0;
			win_cnt <= '0;
			win_base <= '0;
			base_addr <= '0;
			offset <= '0;
		end else if (!active) begin
			if (i_go) begin
				active <= 1'b1; // counters are already at zero
			end
		end else if (final_addr) begin
			active <= 1'b0;
			lane_cnt <= '0;
			chan_cnt <= '0;
			win_cnt <= '0;
			win_base <= '0;
			base_addr <= '0;
			offset <= '0;
		end else if (lane_wrap && chan_wrap) begin
			// jump to the next window start
			win_base <= win_base + stream_buffer_pkg::WINDOW_STRIDE;
			base_addr <= win_base + stream_buffer_pkg::WINDOW_STRIDE;
			win_cnt <= win_cnt + 1'b1;
			chan_cnt <= '0;
			lane_cnt <= '0;
			offset <= '0;
		end else if (lane_wrap) begin
			base_addr <= base_addr + 1'b1;
			chan_cnt <= chan_cnt + 1'b1;
			lane_cnt <= '0;
			offset <= '0;
		end else begin
			offset <= offset + 1'b1;
			lane_cnt <= lane_cnt + 1'b1;
		end
	end

	assign o_addr = base_addr + offset;
	assign o_valid = active;
	assign o_last = final_addr;

endmodule

`default_nettype wire

/* hdl/feature_bank.sv */
`default_nettype none

module feature_bank (
	input wire clk,
	input wire i_reset,
	input wire stream_buffer_pkg::bank_write_t i_write,
	input wire i_go,
	output stream_buffer_pkg::feature_t o_data,
	output logic o_valid,
	output logic o_last
);

	localparam int unsigned LAT = stream_buffer_pkg::READ_LATENCY;

	stream_buffer_pkg::bank_addr_t rd_addr;
	logic walk_valid;
	logic walk_last;
	logic [LAT-1:0] valid_pipe;
	logic [LAT-1:0] last_pipe;

	feature_walker u_walker (
		.clk(clk),
		.i_reset(i_reset),
		.i_go(i_go),
		.o_addr(rd_addr),
		.o_valid(walk_valid),
		.o_last(walk_last)
	);

	feature_ram u_ram (
		.clk(clk),
		.i_we(i_write.en),
		.i_waddr(i_write.addr),
		.i_wdata(i_write.data),
		.i_raddr(rd_addr),
		.o_rdata(o_data)
	);

	// flags follow the address through the ram pipeline
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_pipe <= '0;
			last_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[LAT-2:0], walk_valid};
			last_pipe <= {last_pipe[LAT-2:0], walk_last};
		end
	end

	assign o_valid = valid_pipe[LAT-1];
	assign o_last = last_pipe[LAT-1];

endmodule

`default_nettype wire

/* hdl/stream_buffer_control.sv */
`default_nettype none

module stream_buffer_control (
	input wire clk,
	input wire i_reset,
	input wire i_start,
	input wire i_wen1,
	input wire stream_buffer_pkg::bank_addr_t i_waddr,
	input wire stream_buffer_pkg::feature_t i_pool,
	input wire stream_buffer_pkg::feature_t i_eltwise,
	input wire i_eltwise_sel,
	input wire stream_buffer_pkg::feature_t i_b0_data,
	input wire stream_buffer_pkg::feature_t i_b1_data,
	input wire i_rd_valid,
	input wire i_rd_last,
	output stream_buffer_pkg::bank_write_t o_bank1_write,
	output logic o_sweep_go,
	output stream_buffer_pkg::feature_pair_t o_pair,
	output logic o_valid,
	output logic o_busy,
	output logic o_done
);

	logic running; // idle = 0, sweep in flight = 1
	logic pair_last; // o_pair holds the final pair of the sweep
	logic start_ok;

	assign start_ok = i_start && !running;

	// bank 1 write source mux
	always_comb begin
		o_bank1_write.en = i_wen1;
		o_bank1_write.addr = i_waddr;
		if (i_eltwise_sel) begin
			o_bank1_write.data = i_eltwise;
		end else begin
			o_bank1_write.data = i_pool;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			running <= 1'b0;
			o_sweep_go <= 1'b0;
		end else begin
			o_sweep_go <= start_ok;
			if (start_ok) begin
				running <= 1'b1;
			end else if (pair_last) begin
				running <= 1'b0; // back to idle once the last pair is out
			end
		end
	end

	// output stage, one cycle after the banks
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			pair_last <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_valid <= i_rd_valid;
			pair_last <= i_rd_valid && i_rd_last;
			o_done <= pair_last;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rd_valid) begin
			o_pair.b0 <= i_b0_data;
			o_pair.b1 <= i_b1_data;
		end
	end

	assign o_busy = running;

endmodule

`default_nettype wire

/* hdl/stream_buffer.sv */
`default_nettype none

module stream_buffer (
	input wire clk,
	input wire i_reset,
	input wire stream_buffer_pkg::bank_write_t i_ddr_write,
	input wire stream_buffer_pkg::bank_addr_t i_waddr,
	input wire i_wen1,
	input wire stream_buffer_pkg::feature_t i_pool,
	input wire stream_buffer_pkg::feature_t i_eltwise,
	input wire i_eltwise_sel,
	input wire i_start,
	output stream_buffer_pkg::feature_pair_t o_pair,
	output logic o_valid,
	output logic o_busy,
	output logic o_done
);

	stream_buffer_pkg::bank_write_t bank1_write;
	stream_buffer_pkg::feature_t b0_data;
	stream_buffer_pkg::feature_t b1_data;
	logic sweep_go;
	logic rd_valid;
	logic rd_last;

	stream_buffer_control u_control (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_wen1(i_wen1),
		.i_waddr(i_waddr),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.i_b0_data(b0_data),
		.i_b1_data(b1_data),
		.i_rd_valid(rd_valid),
		.i_rd_last(rd_last),
		.o_bank1_write(bank1_write),
		.o_sweep_go(sweep_go),
		.o_pair(o_pair),
		.o_valid(o_valid),
		.o_busy(o_busy),
		.o_done(o_done)
	);

	// ddr feature maps
	feature_bank u_bank0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_write(i_ddr_write),
		.i_go(sweep_go),
		.o_data(b0_data),
		.o_valid(rd_valid),
		.o_last(rd_last)
	);

	// pool or eltwise results, walks in lock-step with bank 0
	feature_bank u_bank1 (
		.clk(clk),
		.i_reset(i_reset),
		.i_write(bank1_write),
		.i_go(sweep_go),
		.o_data(b1_data),
		.o_valid(),
		.o_last()
	);

endmodule

`default_nettype wire

/* verification/stream_buffer_tb.sv */
`default_nettype none

module stream_buffer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic i_reset;
	stream_buffer_pkg::bank_write_t i_ddr_write;
	stream_buffer_pkg::bank_addr_t i_waddr;
	logic i_wen1;
	stream_buffer_pkg::feature_t i_pool;
	stream_buffer_pkg::feature_t i_eltwise;
	logic i_eltwise_sel;
	logic i_start;
	stream_buffer_pkg::feature_pair_t o_pair;
	logic o_valid;
	logic o_busy;
	logic o_done;

	// reference copies of both banks, updated on every write the testbench makes
	stream_buffer_pkg::feature_t bank0_model [0:stream_buffer_pkg::DEPTH-1];
	stream_buffer_pkg::feature_t bank1_model [0:stream_buffer_pkg::DEPTH-1];

	int unsigned seed_draw;
	int error_count;

	stream_buffer i_dut (
		.clk(clk),
		.i_reset(i_reset),
		.i_ddr_write(i_ddr_write),
		.i_waddr(i_waddr),
		.i_wen1(i_wen1),
		.i_pool(i_pool),
		.i_eltwise(i_eltwise),
		.i_eltwise_sel(i_eltwise_sel),
		.i_start(i_start),
		.o_pair(o_pair),
		.o_valid(o_valid),
		.o_busy(o_busy),
		.o_done(o_done)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	initial begin : watchdog
		int unsigned limit_ns;
		limit_ns = 5 * (stream_buffer_pkg::SWEEP_READS + 64) * 4; // five tests, 4 ns period
		#(limit_ns);
		$display("[ERROR] the run timed out after %0d ns before all tests finished", limit_ns);
		raise_fail();
	end

	task automatic raise_fail();
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_pair(input string name, input stream_buffer_pkg::feature_pair_t actual,
		input stream_buffer_pkg::feature_pair_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			raise_fail();
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			raise_fail();
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			raise_fail();
		end
	endtask

	// one step: rising edge, then the drive and sample point
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// read k of a sweep, lane fastest, then channel, then window
	function automatic stream_buffer_pkg::bank_addr_t rule_addr(input int k);
		int w;
		int c;
		int l;
		w = k / (stream_buffer_pkg::LANES * stream_buffer_pkg::CHANNELS);
		c = (k / stream_buffer_pkg::LANES) % stream_buffer_pkg::CHANNELS;
		l = k % stream_buffer_pkg::LANES;
		return stream_buffer_pkg::bank_addr_t'(w * int'(stream_buffer_pkg::WINDOW_STRIDE) + c + l);
	endfunction

	task automatic drive_write(input stream_buffer_pkg::bank_addr_t addr, input logic we0,
		input stream_buffer_pkg::feature_t d0, input logic we1,
		input stream_buffer_pkg::feature_t d1, input logic sel);
		i_ddr_write.en = we0;
		i_ddr_write.addr = addr;
		i_ddr_write.data = d0;
		i_wen1 = we1;
		i_waddr = addr;
		i_eltwise_sel = sel;
		if (sel) begin
			i_eltwise = d1;
			i_pool = ~d1; // unselected source carries a different word
		end else begin
			i_pool = d1;
			i_eltwise = ~d1;
		end
		if (we0) begin
			bank0_model[addr] = d0;
		end
		if (we1) begin
			bank1_model[addr] = d1;
		end
		next_cycle();
		i_ddr_write.en = 1'b0;
		i_wen1 = 1'b0;
	endtask

	// start a sweep and follow it to the done pulse
	// restart_at >= 0 pulses i_start again while that pair is on the output
	task automatic sweep_and_compare(input int restart_at);
		int count;
		int wait_cycles;
		stream_buffer_pkg::bank_addr_t addr;
		stream_buffer_pkg::feature_pair_t expected;
		count = 0;
		wait_cycles = 0;
		check_bit("o_busy", o_busy, 1'b0);
		i_start = 1'b1;
		next_cycle();
		i_start = 1'b0;
		while (!o_valid) begin
			check_bit("o_busy", o_busy, 1'b1);
			check_bit("o_done", o_done, 1'b0);
			if (wait_cycles > 4 * stream_buffer_pkg::READ_LATENCY) begin
				error_count++;
				$display("[ERROR] no valid pair arrived after the start strobe");
				raise_fail();
			end
			wait_cycles++;
			next_cycle();
		end
		while (o_valid) begin
			if (count == stream_buffer_pkg::SWEEP_READS) begin
				error_count++;
				$display("[ERROR] the sweep produced more pairs than it has reads");
				raise_fail();
			end
			addr = rule_addr(count);
			expected.b0 = bank0_model[addr];
			expected.b1 = bank1_model[addr];
			check_pair($sformatf("o_pair[%0d]", count), o_pair, expected);
			check_bit("o_busy", o_busy, 1'b1);
			check_bit("o_done", o_done, 1'b0);
			i_start = (count == restart_at);
			count++;
			next_cycle();
		end
		i_start = 1'b0;
		check_count("pair count", count, stream_buffer_pkg::SWEEP_READS);
		check_bit("o_done", o_done, 1'b1); // the cycle right after the last pair
		check_bit("o_busy", o_busy, 1'b0);
		next_cycle();
		check_bit("o_done", o_done, 1'b0);
	endtask

	task automatic idle_after_reset();
		repeat (20) begin
			check_bit("o_valid", o_valid, 1'b0);
			check_bit("o_done", o_done, 1'b0);
			check_bit("o_busy", o_busy, 1'b0);
			next_cycle();
		end
	endtask

	task automatic full_sweep();
		stream_buffer_pkg::feature_t d0;
		stream_buffer_pkg::feature_t d1;
		for (int a = 0; a < stream_buffer_pkg::DEPTH; a++) begin
			d0 = stream_buffer_pkg::feature_t'($urandom());
			d1 = stream_buffer_pkg::feature_t'($urandom());
			drive_write(stream_buffer_pkg::bank_addr_t'(a), 1'b1, d0, 1'b1, d1, 1'b0);
		end
		sweep_and_compare(-1);
	endtask

	task automatic bank1_source_select();
		stream_buffer_pkg::feature_t d1;
		for (int a = 8; a < 24; a++) begin
			d1 = bank1_model[a] ^ stream_buffer_pkg::feature_t'($urandom() | 1);
			drive_write(stream_buffer_pkg::bank_addr_t'(a), 1'b0, '0, 1'b1, d1, 1'b1);
		end
		i_eltwise_sel = 1'b0;
		sweep_and_compare(-1);
	endtask

	task automatic done_and_busy();
		sweep_and_compare(-1);
		repeat (8) begin
			check_bit("o_done", o_done, 1'b0);
			check_bit("o_busy", o_busy, 1'b0);
			check_bit("o_valid", o_valid, 1'b0);
			next_cycle();
		end
	endtask

	// the late restart lands after the walkers went idle but while busy is still high
	task automatic start_while_busy();
		sweep_and_compare(60);
		sweep_and_compare(126);
		repeat (8) begin
			check_bit("o_done", o_done, 1'b0);
			check_bit("o_busy", o_busy, 1'b0);
			check_bit("o_valid", o_valid, 1'b0);
			next_cycle();
		end
	endtask

	initial begin
		seed_draw = $urandom(26792);
		error_count = 0;
		i_reset = 1'b1;
		i_ddr_write = '0;
		i_waddr = '0;
		i_wen1 = 1'b0;
		i_pool = '0;
		i_eltwise = '0;
		i_eltwise_sel = 1'b0;
		i_start = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		i_reset = 1'b0;
		idle_after_reset();
		full_sweep();
		bank1_source_select();
		done_and_busy();
		start_while_busy();
		if (error_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			raise_fail();
		end
	end

endmodule

`default_nettype wire

/* tb.f */
hdl/stream_buffer_pkg.sv
hdl/feature_ram.sv
hdl/feature_walker.sv
hdl/feature_bank.sv
hdl/stream_buffer_control.sv
hdl/stream_buffer.sv
verification/stream_buffer_tb.sv

/* Bender.yml */
package:
  name: stream_buffer

sources:
  - files:
      - hdl/stream_buffer_pkg.sv
      - hdl/feature_ram.sv
      - hdl/feature_walker.sv
      - hdl/feature_bank.sv
      - hdl/stream_buffer_control.sv
      - hdl/stream_buffer.sv
  - target: test
    files:
      - verification/stream_buffer_tb.sv
